/* common/miner_cfg.svh */
`ifndef MINER_CFG_SVH
`define MINER_CFG_SVH

// AXI-lite bus geometry
`define MINER_DATA_W		32
`define MINER_ADDR_W		8
`define MINER_ADDR_LSB		2

// Register file size
`define MINER_NUM_REGS		64

// Work packet spans words 1 to 54, first word in the top bits
`define MINER_WORK_FIRST	1
`define MINER_WORK_LAST		54
`define MINER_WORK_W		1728

// Start nonce and target, each two words with the low word first
`define MINER_NONCE_LO		55
`define MINER_TARGET_LO		57

// Interrupt enable and start control words
`define MINER_IRQ_EN_IDX	62
`define MINER_CTRL_IDX		63
`define MINER_CTRL_RESET	1

`endif

/* common/miner_pkg.sv */
`include "miner_cfg.svh"

package miner_pkg;

	////////////////////////////////////////////////////////////////////////////
	//
	// Register word views
	//
	////////////////////////////////////////////////////////////////////////////

	// One bus word, read whole or merged lane by lane under the strobes
	typedef union packed
	{
		logic [`MINER_DATA_W-1:0]		raw;
		logic [`MINER_DATA_W/8-1:0][7:0]	lanes;
	} reg_word_u;

	// One strobe bit per byte lane
	typedef logic [`MINER_DATA_W/8-1:0] byte_strb_t;

	// Word index, the byte address without its low bits
	typedef logic [`MINER_ADDR_W-`MINER_ADDR_LSB-1:0] reg_idx_t;

	// Nonce and target values
	typedef logic [2*`MINER_DATA_W-1:0] nonce_t;

endpackage

/* hw/axil_slave/axil_write_port.sv */
`timescale 1ns/1ps

module axil_write_port
(
	input  logic	S_AXI_ACLK,
	input  logic	i_reset,

	input  logic	i_awvalid,
	input  logic	i_wvalid,
	input  logic	i_bready,

	output logic	o_awready,
	output logic	o_wready,
	output logic	o_bvalid,
	output logic	o_wr_en
);

	logic	accept;
	logic	bvalid;

	////////////////////////////////////////////////////////////////////////////
	//
	// Write acceptance
	//
	////////////////////////////////////////////////////////////////////////////

	// Address and data are taken together, for one cycle only
	// Held off while a response is still waiting on the master
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			accept <= 1'b0;
		else
			accept <= !accept && i_awvalid && i_wvalid
				&& (!bvalid || i_bready);
	end

	assign o_awready = accept;
	assign o_wready  = accept;

	// Register file updates at the end of the accept cycle
	assign o_wr_en = accept;

	////////////////////////////////////////////////////////////////////////////
	//
	// Write response
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			bvalid <= 1'b0;
		else if (accept)
			bvalid <= 1'b1;
		else if (i_bready)
			bvalid <= 1'b0;
	end

	assign o_bvalid = bvalid;

	// Accept pulse never stretches into a second cycle
	a_single_accept : assert property (@(posedge S_AXI_ACLK) disable iff (i_reset)
		o_awready |=> !o_awready);

	// Response held until the master takes it
	a_bvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (i_reset)
		o_bvalid && !i_bready |=> o_bvalid);

endmodule

/* hw/axil_slave/axil_read_port.sv */
`timescale 1ns/1ps

module axil_read_port
(
	input  logic			S_AXI_ACLK,
	input  logic			i_reset,

	input  logic			i_arvalid,
	input  logic			i_rready,
	input  miner_pkg::reg_word_u	i_rd_word,

	output logic			o_arready,
	output logic			o_rvalid,
	output logic			o_rd_ld,
	output miner_pkg::reg_word_u	o_rdata
);

	logic			rvalid;
	logic			rd_hs;
	miner_pkg::reg_word_u	rdata;

	////////////////////////////////////////////////////////////////////////////
	//
	// Read address handshake
	//
	////////////////////////////////////////////////////////////////////////////

	// Only one read in flight, so ready simply follows the valid flag
	assign o_arready = !rvalid;
	assign rd_hs     = i_arvalid && !rvalid;
	assign o_rd_ld   = rd_hs;

	////////////////////////////////////////////////////////////////////////////
	//
	// Read data channel
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			rvalid <= 1'b0;
		else if (rd_hs)
			rvalid <= 1'b1;
		else if (i_rready)
			rvalid <= 1'b0;
	end

	// Word as it stood in the handshake cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			rdata <= '0;
		else if (rd_hs)
			rdata <= i_rd_word;
	end

	assign o_rvalid = rvalid;
	assign o_rdata  = rdata;

	// Data must not move while the master is stalling
	a_rdata_stable : assert property (@(posedge S_AXI_ACLK) disable iff (i_reset)
		o_rvalid && !i_rready |=> $stable(o_rdata));

endmodule

/* hw/miner_regs.sv */
`timescale 1ns/1ps

`include "miner_cfg.svh"

module miner_regs
(
	input  logic			S_AXI_ACLK,
	input  logic			i_reset,

	input  logic			i_wr_en,
	input  miner_pkg::reg_idx_t	i_wr_idx,
	input  miner_pkg::reg_word_u	i_wr_data,
	input  miner_pkg::byte_strb_t	i_wr_strb,
	input  miner_pkg::reg_idx_t	i_rd_idx,

	output miner_pkg::reg_word_u	o_rd_word,
	output logic [`MINER_WORK_W-1:0]	o_work_pkt,
	output miner_pkg::nonce_t	o_start_nonce,
	output miner_pkg::nonce_t	o_target,
	output logic			o_start,
	output logic			o_irq_en
);

	miner_pkg::reg_word_u	regs [0:`MINER_NUM_REGS-1];
	miner_pkg::reg_word_u	merged;

	////////////////////////////////////////////////////////////////////////////
	//
	// Strobe merge and register update
	//
	////////////////////////////////////////////////////////////////////////////

	// Lanes without a strobe keep their old byte
	always_comb
	begin
		merged = regs[i_wr_idx];
		for (int b = 0; b < `MINER_DATA_W/8; b++)
		begin
			if (i_wr_strb[b])
				merged.lanes[b] = i_wr_data.lanes[b];
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
		begin
			for (int k = 0; k < `MINER_NUM_REGS; k++)
				regs[k] <= '0;
			regs[`MINER_CTRL_IDX].raw <= `MINER_CTRL_RESET;
		end
		else if (i_wr_en)
			regs[i_wr_idx] <= merged;
		else if (regs[`MINER_CTRL_IDX].raw[0])
			// Start bit lasts one idle cycle
			regs[`MINER_CTRL_IDX].raw[0] <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Read mux and field outputs
	//
	////////////////////////////////////////////////////////////////////////////

	assign o_rd_word = regs[i_rd_idx];

	// Word 1 lands in the most significant bits of the packet
	genvar gw;
	generate
		for (gw = `MINER_WORK_FIRST; gw <= `MINER_WORK_LAST; gw++)
		begin : g_work
			assign o_work_pkt[(`MINER_WORK_LAST-gw)*`MINER_DATA_W +: `MINER_DATA_W]
				= regs[gw].raw;
		end
	endgenerate

	// Lower word index is the low half
	assign o_start_nonce = {regs[`MINER_NONCE_LO+1].raw, regs[`MINER_NONCE_LO].raw};
	assign o_target      = {regs[`MINER_TARGET_LO+1].raw, regs[`MINER_TARGET_LO].raw};

	assign o_start  = regs[`MINER_CTRL_IDX].raw[0];
	assign o_irq_en = regs[`MINER_IRQ_EN_IDX].raw[0];

endmodule

/* hw/miner_ctrl.sv */
`timescale 1ns/1ps

module miner_ctrl
(
	input  logic			S_AXI_ACLK,
	input  logic			i_reset,

	// From the register file
	input  logic			i_start,
	input  logic			i_irq_en,

	// From the hash core
	input  logic			i_good_nonce,
	input  logic			i_irq_ack,
	input  miner_pkg::nonce_t	i_nonce_found,

	output logic			o_hash_rst_n,
	output logic			o_irq,
	output miner_pkg::nonce_t	o_irq_nonce
);

	logic			hash_rst_n;
	logic			irq;
	miner_pkg::nonce_t	irq_nonce;
	logic			nonce_hit;
	logic			ack_hit;

	////////////////////////////////////////////////////////////////////////////
	//
	// Hash core reset
	//
	////////////////////////////////////////////////////////////////////////////

	// Low for one cycle behind each cycle the start bit is set
	// Comes out of reset low, since the start word resets to 1
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			hash_rst_n <= 1'b0;
		else
			hash_rst_n <= !i_start;
	end

	assign o_hash_rst_n = hash_rst_n;

	////////////////////////////////////////////////////////////////////////////
	//
	// Nonce capture and interrupt
	//
	////////////////////////////////////////////////////////////////////////////

	// Both events only count while the interrupt is enabled
	assign nonce_hit = i_good_nonce && i_irq_en;
	assign ack_hit   = i_irq_ack && i_irq_en;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			irq_nonce <= '0;
		else if (nonce_hit)
			irq_nonce <= i_nonce_found;
	end

	// A fresh nonce beats an acknowledge in the same cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reset)
			irq <= 1'b0;
		else if (nonce_hit)
			irq <= 1'b1;
		else if (ack_hit)
			irq <= 1'b0;
	end

	assign o_irq       = irq;
	assign o_irq_nonce = irq_nonce;

	// Interrupt only rises when the enable word allowed it
	a_irq_needs_en : assert property (@(posedge S_AXI_ACLK) disable iff (i_reset)
		$rose(o_irq) |-> $past(i_irq_en));

endmodule

/* hw/miner_saxil_top.sv */
`timescale 1ns/1ps

`include "miner_cfg.svh"

module miner_saxil_top
(
	input  logic				S_AXI_ACLK,
	input  logic				i_reset,

	// AXI-lite write address, data and response
	input  logic				i_awvalid,
	input  logic [`MINER_ADDR_W-1:0]	i_awaddr,
	input  logic				i_wvalid,
	input  logic [`MINER_DATA_W-1:0]	i_wdata,
	input  logic [`MINER_DATA_W/8-1:0]	i_wstrb,
	input  logic				i_bready,
	output logic				o_awready,
	output logic				o_wready,
	output logic				o_bvalid,
	output logic [1:0]			o_bresp,

	// AXI-lite read address and data
	input  logic				i_arvalid,
	input  logic [`MINER_ADDR_W-1:0]	i_araddr,
	input  logic				i_rready,
	output logic				o_arready,
	output logic				o_rvalid,
	output logic [`MINER_DATA_W-1:0]	o_rdata,
	output logic [1:0]			o_rresp,

	// Hash core side
	input  logic				i_good_nonce,
	input  miner_pkg::nonce_t		i_nonce_found,
	input  logic				i_irq_ack,
	output logic				o_irq,
	output miner_pkg::nonce_t		o_irq_nonce,
	output logic				o_hash_rst_n,
	output logic [`MINER_WORK_W-1:0]	o_work_pkt,
	output miner_pkg::nonce_t		o_start_nonce,
	output miner_pkg::nonce_t		o_target
);

	logic			wr_en;
	logic			start;
	logic			irq_en;
	miner_pkg::reg_idx_t	wr_idx;
	miner_pkg::reg_idx_t	rd_idx;
	miner_pkg::reg_word_u	rd_word;
	miner_pkg::reg_word_u	rdata;

	// Word index from the byte addresses
	assign wr_idx = i_awaddr[`MINER_ADDR_W-1:`MINER_ADDR_LSB];
	assign rd_idx = i_araddr[`MINER_ADDR_W-1:`MINER_ADDR_LSB];

	// Every access completes as OKAY
	assign o_bresp = 2'b00;
	assign o_rresp = 2'b00;

	////////////////////////////////////////////////////////////////////////////
	//
	// Bus channels
	//
	////////////////////////////////////////////////////////////////////////////

	axil_write_port u_wr_port
	(
		.S_AXI_ACLK	(S_AXI_ACLK),
		.i_reset	(i_reset),
		.i_awvalid	(i_awvalid),
		.i_wvalid	(i_wvalid),
		.i_bready	(i_bready),
		.o_awready	(o_awready),
		.o_wready	(o_wready),
		.o_bvalid	(o_bvalid),
		.o_wr_en	(wr_en)
	);

	axil_read_port u_rd_port
	(
		.S_AXI_ACLK	(S_AXI_ACLK),
		.i_reset	(i_reset),
		.i_arvalid	(i_arvalid),
		.i_rready	(i_rready),
		.i_rd_word	(rd_word),
		.o_arready	(o_arready),
		.o_rvalid	(o_rvalid),
		.o_rd_ld	(),
		.o_rdata	(rdata)
	);

	assign o_rdata = rdata.raw;

	////////////////////////////////////////////////////////////////////////////
	//
	// Registers and core control
	//
	////////////////////////////////////////////////////////////////////////////

	miner_regs u_regs
	(
		.S_AXI_ACLK	(S_AXI_ACLK),
		.i_reset	(i_reset),
		.i_wr_en	(wr_en),
		.i_wr_idx	(wr_idx),
		.i_wr_data	(i_wdata),
		.i_wr_strb	(i_wstrb),
		.i_rd_idx	(rd_idx),
		.o_rd_word	(rd_word),
		.o_work_pkt	(o_work_pkt),
		.o_start_nonce	(o_start_nonce),
		.o_target	(o_target),
		.o_start	(start),
		.o_irq_en	(irq_en)
	);

	miner_ctrl u_ctrl
	(
		.S_AXI_ACLK	(S_AXI_ACLK),
		.i_reset	(i_reset),
		.i_start	(start),
		.i_irq_en	(irq_en),
		.i_good_nonce	(i_good_nonce),
		.i_irq_ack	(i_irq_ack),
		.i_nonce_found	(i_nonce_found),
		.o_hash_rst_n	(o_hash_rst_n),
		.o_irq		(o_irq),
		.o_irq_nonce	(o_irq_nonce)
	);

endmodule

/* verif/tb_miner_ref.svh */
`ifndef TB_MINER_REF_SVH
`define TB_MINER_REF_SVH

// Expected word after a strobed write, one byte lane at a time
function automatic logic [`MINER_DATA_W-1:0] merge_strb(input logic [`MINER_DATA_W-1:0] old_word,
	input logic [`MINER_DATA_W-1:0] new_word, input logic [`MINER_DATA_W/8-1:0] strb);
	logic [`MINER_DATA_W-1:0] res;
	begin
		res = old_word;
		for (int b = 0; b < `MINER_DATA_W/8; b++)
		begin
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	end
endfunction

// Work words shifted in from the bottom, so word 1 ends up on top
function automatic logic [`MINER_WORK_W-1:0] ref_work_pkt(
	input logic [`MINER_DATA_W-1:0] words [0:`MINER_NUM_REGS-1]);
	logic [`MINER_WORK_W-1:0] pkt;
	begin
		pkt = '0;
		for (int w = `MINER_WORK_FIRST; w <= `MINER_WORK_LAST; w++)
			pkt = {pkt[`MINER_WORK_W-`MINER_DATA_W-1:0], words[w]};
		return pkt;
	end
endfunction

// Two-word value, low half from the lower index
function automatic logic [2*`MINER_DATA_W-1:0] ref_pair(
	input logic [`MINER_DATA_W-1:0] words [0:`MINER_NUM_REGS-1], input int lo);
	begin
		return {words[lo+1], words[lo]};
	end
endfunction

`endif

/* verif/tb_miner_saxil.sv */
`timescale 1ns/1ps

`include "miner_cfg.svh"

module tb_miner_saxil;

	localparam int CLK_PERIOD = 40;
	localparam int WAIT_LIMIT = 40;
	localparam int NUM_WRITES = 120;
	localparam int NUM_STALLS = 12;

	logic				S_AXI_ACLK;
	logic				i_reset;
	logic				i_awvalid;
	logic [`MINER_ADDR_W-1:0]	i_awaddr;
	logic				i_wvalid;
	logic [`MINER_DATA_W-1:0]	i_wdata;
	logic [`MINER_DATA_W/8-1:0]	i_wstrb;
	logic				i_bready;
	logic				o_awready;
	logic				o_wready;
	logic				o_bvalid;
	logic [1:0]			o_bresp;
	logic				i_arvalid;
	logic [`MINER_ADDR_W-1:0]	i_araddr;
	logic				i_rready;
	logic				o_arready;
	logic				o_rvalid;
	logic [`MINER_DATA_W-1:0]	o_rdata;
	logic [1:0]			o_rresp;
	logic				i_good_nonce;
	logic [2*`MINER_DATA_W-1:0]	i_nonce_found;
	logic				i_irq_ack;
	logic				o_irq;
	logic [2*`MINER_DATA_W-1:0]	o_irq_nonce;
	logic				o_hash_rst_n;
	logic [`MINER_WORK_W-1:0]	o_work_pkt;
	logic [2*`MINER_DATA_W-1:0]	o_start_nonce;
	logic [2*`MINER_DATA_W-1:0]	o_target;

	// Expected register contents and the reads still waiting for data
	logic [`MINER_DATA_W-1:0]	shadow [0:`MINER_NUM_REGS-1];
	logic [`MINER_DATA_W-1:0]	exp_q [$];
	integer				seed = 32'h74c6;

	`include "tb_miner_ref.svh"

	miner_saxil_top UUT (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(CLK_PERIOD/2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Checks and helpers
	//
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s, got %h expected %h", $time, what, got, exp));
	endtask

	// One clock of a bounded wait
	task automatic step_clock(inout int n, input string what);
		@(posedge S_AXI_ACLK);
		n++;
		if (n > WAIT_LIMIT)
			stop_on_error($sformatf("Timed out at %0t waiting for %s", $time, what));
	endtask

	function automatic int unsigned rand_below(input int unsigned limit);
		int unsigned r;
		r = $random(seed);
		return r % limit;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	//
	// Bus tasks
	//
	////////////////////////////////////////////////////////////////////////////

	// Stall holds BREADY low and keeps the write on the bus after acceptance
	task automatic bus_write(input logic [5:0] idx, input logic [31:0] data,
		input logic [3:0] strb, input int stall);
		int n;
		i_awvalid <= 1'b1;
		i_awaddr  <= {idx, 2'b00};
		i_wvalid  <= 1'b1;
		i_wdata   <= data;
		i_wstrb   <= strb;
		i_bready  <= (stall == 0);
		n = 0;
		do
			step_clock(n, "write accept");
		while (!(o_awready && o_wready));
		shadow[idx] = merge_strb(shadow[idx], data, strb);
		for (int k = 0; k < stall; k++)
		begin
			@(posedge S_AXI_ACLK);
			check_value(64'(o_bvalid), 64'd1, "bvalid held under back-pressure");
			check_value(64'(o_awready), 64'd0, "awready under back-pressure");
		end
		i_awvalid <= 1'b0;
		i_wvalid  <= 1'b0;
		i_bready  <= 1'b1;
		n = 0;
		do
			step_clock(n, "write response");
		while (!(o_bvalid && i_bready));
		check_value(64'(o_bresp), 64'd0, "write response code");
	endtask

	// Data itself is checked by the compare process
	task automatic bus_read(input logic [5:0] idx, input int stall);
		int n;
		logic [31:0] held;
		i_arvalid <= 1'b1;
		i_araddr  <= {idx, 2'b00};
		i_rready  <= (stall == 0);
		n = 0;
		do
			step_clock(n, "read address");
		while (!(o_arready && i_arvalid));
		i_arvalid <= 1'b0;
		exp_q.push_back(shadow[idx]);
		held = shadow[idx];
		for (int k = 0; k < stall; k++)
		begin
			@(posedge S_AXI_ACLK);
			check_value(64'(o_rvalid), 64'd1, "rvalid held under back-pressure");
			check_value(64'(o_rdata), 64'(held), "rdata stable under back-pressure");
			check_value(64'(o_arready), 64'd0, "arready while rvalid");
		end
		i_rready <= 1'b1;
		n = 0;
		do
			step_clock(n, "read data");
		while (!(o_rvalid && i_rready));
	endtask

	// Read responses against the shadow copy taken at the address handshake
	always @(posedge S_AXI_ACLK)
	begin
		if (!i_reset && o_rvalid && i_rready)
		begin
			check_value(64'(o_rresp), 64'd0, "read response code");
			if (exp_q.size() == 0)
				stop_on_error("Read response arrived with no read outstanding");
			else
				check_value(64'(o_rdata), 64'(exp_q.pop_front()), "read data");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Stimulus
	//
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [63:0]			nonce;
		logic [63:0]			held_nonce;
		logic [`MINER_WORK_W-1:0]	ref_pkt;
		int				n;

		i_reset       = 1'b1;
		i_awvalid     = 1'b0;
		i_awaddr      = '0;
		i_wvalid      = 1'b0;
		i_wdata       = '0;
		i_wstrb       = '0;
		i_bready      = 1'b1;
		i_arvalid     = 1'b0;
		i_araddr      = '0;
		i_rready      = 1'b1;
		i_good_nonce  = 1'b0;
		i_nonce_found = '0;
		i_irq_ack     = 1'b0;
		for (int k = 0; k < `MINER_NUM_REGS; k++)
			shadow[k] = '0;

		repeat (2) @(posedge S_AXI_ACLK);
		i_reset <= 1'b0;

		// Idle outputs, then the start bit left over from reset clears
		@(posedge S_AXI_ACLK);
		check_value(64'(o_bvalid), 64'd0, "bvalid after reset");
		check_value(64'(o_rvalid), 64'd0, "rvalid after reset");
		check_value(64'(o_irq), 64'd0, "irq after reset");
		check_value(o_irq_nonce, 64'd0, "irq nonce after reset");
		n = 0;
		do
			step_clock(n, "hash reset release");
		while (!o_hash_rst_n);
		for (int k = 0; k < `MINER_NUM_REGS; k++)
			bus_read(6'(k), 0);

		// Random strobed writes, read back against the shadow
		for (int k = 0; k < NUM_WRITES; k++)
			bus_write(6'(rand_below(62)), $random(seed), 4'(rand_below(16)), 0);
		for (int k = 0; k < 62; k++)
			bus_read(6'(k), 0);

		ref_pkt = ref_work_pkt(shadow);
		for (int k = 0; k < `MINER_WORK_W/`MINER_DATA_W; k++)
			check_value(64'(o_work_pkt[k*32 +: 32]), 64'(ref_pkt[k*32 +: 32]), "work packet");
		check_value(o_start_nonce, ref_pair(shadow, `MINER_NONCE_LO), "start nonce");
		check_value(o_target, ref_pair(shadow, `MINER_TARGET_LO), "target");

		// Start pulse, and the bit reads back cleared
		bus_write(6'd63, 32'd1, 4'hF, 0);
		shadow[63] = '0;
		n = 0;
		do
			step_clock(n, "hash reset pulse");
		while (o_hash_rst_n);
		n = 0;
		do
			step_clock(n, "hash reset release");
		while (!o_hash_rst_n);
		bus_read(6'd63, 0);

		// Interrupt enabled
		bus_write(6'd62, 32'd1, 4'hF, 0);
		nonce = {$random(seed), $random(seed)};
		i_nonce_found <= nonce;
		i_good_nonce  <= 1'b1;
		@(posedge S_AXI_ACLK);
		i_good_nonce <= 1'b0;
		n = 0;
		do
			step_clock(n, "interrupt");
		while (!o_irq);
		check_value(o_irq_nonce, nonce, "captured nonce");
		repeat (3)
		begin
			@(posedge S_AXI_ACLK);
			check_value(64'(o_irq), 64'd1, "irq held until acknowledge");
		end
		i_irq_ack <= 1'b1;
		n = 0;
		do
			step_clock(n, "interrupt clear");
		while (o_irq);
		i_irq_ack <= 1'b0;

		// Interrupt disabled, nonce is ignored
		held_nonce = nonce;
		bus_write(6'd62, 32'd0, 4'hF, 0);
		i_nonce_found <= {$random(seed), $random(seed)};
		i_good_nonce  <= 1'b1;
		@(posedge S_AXI_ACLK);
		i_good_nonce <= 1'b0;
		repeat (4)
		begin
			@(posedge S_AXI_ACLK);
			check_value(64'(o_irq), 64'd0, "irq while disabled");
			check_value(o_irq_nonce, held_nonce, "nonce kept while disabled");
		end

		// Back-pressure on both response channels
		for (int k = 0; k < NUM_STALLS; k++)
		begin
			bus_write(6'(k), $random(seed), 4'(rand_below(16)), 1 + int'(rand_below(6)));
			bus_read(6'(k), 1 + int'(rand_below(6)));
		end

		@(posedge S_AXI_ACLK);
		if (exp_q.size() != 0)
			stop_on_error("Some reads never returned a response");
		else
		begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

/* all.f */
+incdir+common
+incdir+verif
common/miner_pkg.sv
hw/axil_slave/axil_write_port.sv
hw/axil_slave/axil_read_port.sv
hw/miner_regs.sv
hw/miner_ctrl.sv
hw/miner_saxil_top.sv
verif/tb_miner_saxil.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# The simulator exits non-zero when the testbench stops on $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f all.f \
	--top-module tb_miner_saxil \
	--Mdir obj_dir \
	-o sim_miner

./obj_dir/sim_miner
